// File: rtl/vwrite_pkg.sv
package vwrite_pkg;

   // data and external addressing
   typedef logic [31:0] word_t;
   typedef logic [31:0] ext_addr_t;
   // beats minus one
   typedef logic [7:0]  burst_len_t;

   // config widths, low ADDR_W bits of an address are used
   typedef logic [15:0] cfg_addr_t;
   typedef logic [15:0] period_t;
   typedef logic [7:0]  delay_t;

   typedef struct packed {
      cfg_addr_t start;
      cfg_addr_t incr;
      period_t   period;
      period_t   duty;
      cfg_addr_t iterations;
      cfg_addr_t shift;
      delay_t    delay;
   } agen_cfg_t;

   typedef struct packed {
      ext_addr_t  ext_addr;
      cfg_addr_t  amount_minus_one;
      burst_len_t length;
      logic       enabled;
   } xfer_cfg_t;

   typedef struct packed {
      logic       valid;
      ext_addr_t  addr;
      burst_len_t len;
      word_t      wdata;
   } databus_req_t;

   typedef enum logic [1:0] {AGEN_IDLE, AGEN_DELAY, AGEN_RUN, AGEN_DONE} agen_state_e;
   typedef enum logic [1:0] {BURST_IDLE, BURST_REQ, BURST_BEAT, BURST_DONE} burst_state_e;

endpackage

// File: rtl/addr_gen.sv
`timescale 1ns/10ps

module addr_gen #(
   parameter int ADDR_W  = 10,
   parameter bit COMPACT = 1'b0
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  vwrite_pkg::agen_cfg_t cfg_i,
   output logic                  valid_o,
   input  logic                  ready_i,
   output logic [ADDR_W-1:0]     addr_o,
   output logic                  done_o
);

   vwrite_pkg::agen_state_e state_q;
   vwrite_pkg::delay_t      delay_q;
   vwrite_pkg::period_t     slot_q;
   vwrite_pkg::cfg_addr_t   iter_q;
   vwrite_pkg::cfg_addr_t   row_addr_q;
   vwrite_pkg::cfg_addr_t   addr_q;
   logic                    advance;
   logic                    row_end;

   assign valid_o = (state_q == vwrite_pkg::AGEN_RUN) && (slot_q < cfg_i.duty);
   assign addr_o  = addr_q[ADDR_W-1:0];
   assign done_o  = (state_q == vwrite_pkg::AGEN_DONE);

   // slots past duty never wait for ready
   assign advance = (state_q == vwrite_pkg::AGEN_RUN) && (ready_i || !valid_o);

   // compact mode closes the period at its last valid slot,
   // so a consumer sees no gaps inside the pattern
   assign row_end = (slot_q == cfg_i.period - 16'd1) ||
                    (COMPACT && (slot_q == cfg_i.duty - 16'd1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q    <= vwrite_pkg::AGEN_IDLE;
         delay_q    <= '0;
         slot_q     <= '0;
         iter_q     <= '0;
         row_addr_q <= '0;
         addr_q     <= '0;
      end else if (run_i) begin
         delay_q    <= cfg_i.delay;
         slot_q     <= '0;
         iter_q     <= '0;
         row_addr_q <= cfg_i.start;
         addr_q     <= cfg_i.start;
         if ((cfg_i.iterations == '0) || (cfg_i.period == '0)) begin
            state_q <= vwrite_pkg::AGEN_DONE;
         end else if (cfg_i.delay == '0) begin
            state_q <= vwrite_pkg::AGEN_RUN;
         end else begin
            state_q <= vwrite_pkg::AGEN_DELAY;
         end
      end else begin
         case (state_q)
            vwrite_pkg::AGEN_DELAY: begin
               delay_q <= delay_q - 8'd1;
               if (delay_q == 8'd1) begin
                  state_q <= vwrite_pkg::AGEN_RUN;
               end
            end
            vwrite_pkg::AGEN_RUN: begin
               if (advance) begin
                  if (row_end) begin
                     slot_q <= '0;
                     if (iter_q == cfg_i.iterations - 16'd1) begin
                        state_q <= vwrite_pkg::AGEN_DONE;
                     end else begin
                        // next row starts one shift past the previous row start
                        iter_q     <= iter_q + 16'd1;
                        row_addr_q <= row_addr_q + cfg_i.shift;
                        addr_q     <= row_addr_q + cfg_i.shift;
                     end
                  end else begin
                     slot_q <= slot_q + 16'd1;
                     addr_q <= addr_q + cfg_i.incr;
                  end
               end
            end
            default: begin
            end
         endcase
      end
   end

   // a stalled slot keeps its address until taken
   addr_hold_a: assert property (@(posedge clk) disable iff (rst)
      valid_o && !ready_i && !run_i |=> valid_o && $stable(addr_o));

endmodule

// File: rtl/mem_reader.sv
`timescale 1ns/10ps

module mem_reader #(
   parameter int ADDR_W = 10
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              s_valid_i,
   output logic              s_ready_o,
   input  logic [ADDR_W-1:0] s_addr_i,
   output logic              m_valid_o,
   input  logic              m_ready_i,
   output vwrite_pkg::word_t m_data_o,
   output logic              mem_en_o,
   output logic [ADDR_W-1:0] mem_addr_o,
   input  vwrite_pkg::word_t mem_data_i
);

   vwrite_pkg::word_t entry_q [2];
   logic [1:0]        count_q;
   logic              wr_ptr_q;
   logic              rd_ptr_q;
   logic              inflight_q;
   logic [1:0]        occupancy;
   logic              out_fire;
   logic              accept;
   logic              push;
   logic              pop;

   // an empty buffer lets the returning word straight through
   assign m_valid_o = (count_q != 2'd0) || inflight_q;
   assign m_data_o  = (count_q != 2'd0) ? entry_q[rd_ptr_q] : mem_data_i;
   assign out_fire  = m_valid_o && m_ready_i;

   // held words plus the read on its way back
   assign occupancy = count_q + {1'b0, inflight_q};
   assign s_ready_o = (occupancy < 2'd2) || ((occupancy == 2'd2) && out_fire);
   assign accept    = s_valid_i && s_ready_o;

   assign mem_en_o   = accept;
   assign mem_addr_o = s_addr_i;

   assign push = inflight_q && !((count_q == 2'd0) && m_ready_i);
   assign pop  = (count_q != 2'd0) && m_ready_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_q    <= 2'd0;
         wr_ptr_q   <= 1'b0;
         rd_ptr_q   <= 1'b0;
         inflight_q <= 1'b0;
      end else begin
         inflight_q <= accept;
         if (push) begin
            wr_ptr_q <= !wr_ptr_q;
         end
         if (pop) begin
            rd_ptr_q <= !rd_ptr_q;
         end
         count_q <= count_q + {1'b0, push} - {1'b0, pop};
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entry_q[wr_ptr_q] <= mem_data_i;
      end
   end

   no_overflow_a: assert property (@(posedge clk) disable iff (rst)
      push && !pop |-> count_q != 2'd2);

endmodule

// File: rtl/databus_burst.sv
`timescale 1ns/10ps

module databus_burst (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run_i,
   input  vwrite_pkg::xfer_cfg_t    cfg_i,
   input  logic                     data_valid_i,
   input  vwrite_pkg::word_t        data_i,
   output logic                     data_ready_o,
   output vwrite_pkg::databus_req_t bus_o,
   input  logic                     bus_ready_i,
   input  logic                     bus_last_i,
   output logic                     done_o
);

   vwrite_pkg::burst_state_e state_q;
   vwrite_pkg::burst_len_t   len_max_q;
   vwrite_pkg::burst_len_t   len_q;
   vwrite_pkg::ext_addr_t    addr_q;
   logic [16:0]              remain_q;
   logic [16:0]              beats_max;
   logic [16:0]              beats_next;
   logic [16:0]              beats_cur;
   logic                     burst_end;

   // beats of the next burst, capped by the configured length
   assign beats_max  = {9'd0, len_max_q} + 17'd1;
   assign beats_next = (remain_q < beats_max) ? remain_q : beats_max;
   assign beats_cur  = {9'd0, len_q} + 17'd1;
   assign burst_end  = (state_q == vwrite_pkg::BURST_BEAT) && bus_ready_i && bus_last_i;

   always_comb begin
      bus_o.valid = (state_q == vwrite_pkg::BURST_BEAT);
      bus_o.addr  = addr_q;
      bus_o.len   = len_q;
      bus_o.wdata = data_i;
   end

   assign data_ready_o = (state_q == vwrite_pkg::BURST_BEAT) && bus_ready_i;
   assign done_o       = (state_q == vwrite_pkg::BURST_DONE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q   <= vwrite_pkg::BURST_IDLE;
         len_max_q <= '0;
         len_q     <= '0;
         addr_q    <= '0;
         remain_q  <= '0;
      end else if (run_i) begin
         remain_q  <= {1'b0, cfg_i.amount_minus_one} + 17'd1;
         len_max_q <= cfg_i.length;
         addr_q    <= cfg_i.ext_addr;
         state_q   <= cfg_i.enabled ? vwrite_pkg::BURST_REQ : vwrite_pkg::BURST_DONE;
      end else begin
         case (state_q)
            vwrite_pkg::BURST_REQ: begin
               // open the burst only once the first word is there
               if (data_valid_i) begin
                  len_q   <= vwrite_pkg::burst_len_t'(beats_next - 17'd1);
                  state_q <= vwrite_pkg::BURST_BEAT;
               end
            end
            vwrite_pkg::BURST_BEAT: begin
               if (burst_end) begin
                  remain_q <= remain_q - beats_cur;
                  // four bytes per word
                  addr_q   <= addr_q + vwrite_pkg::ext_addr_t'({beats_cur, 2'b00});
                  if (remain_q == beats_cur) begin
                     state_q <= vwrite_pkg::BURST_DONE;
                  end else begin
                     state_q <= vwrite_pkg::BURST_REQ;
                  end
               end
            end
            default: begin
            end
         endcase
      end
   end

   valid_held_a: assert property (@(posedge clk) disable iff (rst)
      bus_o.valid && !(bus_ready_i && bus_last_i) && !run_i |=> bus_o.valid);

   // read side must keep the burst fed
   data_fed_a: assert property (@(posedge clk) disable iff (rst)
      bus_o.valid |-> data_valid_i);

endmodule

// File: rtl/buffer_mem_2p.sv
`timescale 1ns/10ps

module buffer_mem_2p #(
   parameter int ADDR_W = 10
) (
   input  logic              clk,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  vwrite_pkg::word_t wdata_i,
   input  logic              re_i,
   input  logic [ADDR_W-1:0] raddr_i,
   output vwrite_pkg::word_t rdata_o
);

   vwrite_pkg::word_t mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // read data holds until the next read
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

// File: rtl/vwrite_unit.sv
`timescale 1ns/10ps

module vwrite_unit #(
   parameter int ADDR_W = 10
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run_i,
   input  logic                     running_i,
   input  logic                     ping_pong_i,
   input  vwrite_pkg::word_t        in_data_i,
   input  vwrite_pkg::agen_cfg_t    store_cfg_i,
   input  vwrite_pkg::agen_cfg_t    read_cfg_i,
   input  vwrite_pkg::xfer_cfg_t    xfer_cfg_i,
   output logic                     done_o,
   output vwrite_pkg::databus_req_t databus_o,
   input  logic                     databus_ready_i,
   input  logic                     databus_last_i,
   output logic                     mem_we_o,
   output logic [ADDR_W-1:0]        mem_waddr_o,
   output vwrite_pkg::word_t        mem_wdata_o,
   output logic                     mem_re_o,
   output logic [ADDR_W-1:0]        mem_raddr_o,
   input  vwrite_pkg::word_t        mem_rdata_i
);

   logic              pp_q;
   logic              store_done_q;
   logic              xfer_done_q;
   logic              store_valid;
   logic [ADDR_W-1:0] store_addr_raw;
   logic              store_done;
   logic              read_run;
   logic              read_valid;
   logic              read_ready;
   logic [ADDR_W-1:0] read_addr_raw;
   logic [ADDR_W-1:0] read_addr;
   logic              data_valid;
   logic              data_ready;
   vwrite_pkg::word_t data;
   logic              burst_done;

   // ping-pong bit flips per run, store takes it, read takes the other half
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_q <= 1'b0;
      end else if (run_i) begin
         pp_q <= ping_pong_i ? !pp_q : 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         store_done_q <= 1'b1;
         xfer_done_q  <= 1'b1;
      end else if (run_i) begin
         store_done_q <= 1'b0;
         xfer_done_q  <= !xfer_cfg_i.enabled;
      end else begin
         if (running_i && store_done) begin
            store_done_q <= 1'b1;
         end
         if (burst_done) begin
            xfer_done_q <= 1'b1;
         end
      end
   end

   assign done_o = store_done_q && xfer_done_q;

   addr_gen #(.ADDR_W(ADDR_W), .COMPACT(1'b0)) store_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .cfg_i  (store_cfg_i),
      .valid_o(store_valid),
      .ready_i(1'b1),
      .addr_o (store_addr_raw),
      .done_o (store_done)
   );

   assign mem_we_o    = store_valid;
   assign mem_waddr_o = {ping_pong_i ? pp_q : store_addr_raw[ADDR_W-1],
                         store_addr_raw[ADDR_W-2:0]};
   assign mem_wdata_o = in_data_i;

   // no read traffic when the run has no transfer
   assign read_run = run_i && xfer_cfg_i.enabled;

   addr_gen #(.ADDR_W(ADDR_W), .COMPACT(1'b1)) read_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (read_run),
      .cfg_i  (read_cfg_i),
      .valid_o(read_valid),
      .ready_i(read_ready),
      .addr_o (read_addr_raw),
      .done_o ()
   );

   assign read_addr = {ping_pong_i ? !pp_q : read_addr_raw[ADDR_W-1],
                       read_addr_raw[ADDR_W-2:0]};

   mem_reader #(.ADDR_W(ADDR_W)) reader (
      .clk       (clk),
      .rst       (rst),
      .s_valid_i (read_valid),
      .s_ready_o (read_ready),
      .s_addr_i  (read_addr),
      .m_valid_o (data_valid),
      .m_ready_i (data_ready),
      .m_data_o  (data),
      .mem_en_o  (mem_re_o),
      .mem_addr_o(mem_raddr_o),
      .mem_data_i(mem_rdata_i)
   );

   databus_burst burst (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .cfg_i       (xfer_cfg_i),
      .data_valid_i(data_valid),
      .data_i      (data),
      .data_ready_o(data_ready),
      .bus_o       (databus_o),
      .bus_ready_i (databus_ready_i),
      .bus_last_i  (databus_last_i),
      .done_o      (burst_done)
   );

   // patterns must stay inside one half in ping-pong mode
   pp_store_half_a: assert property (@(posedge clk) disable iff (rst)
      ping_pong_i && store_valid |-> !store_addr_raw[ADDR_W-1]);
   pp_read_half_a: assert property (@(posedge clk) disable iff (rst)
      ping_pong_i && read_valid |-> !read_addr_raw[ADDR_W-1]);

endmodule

// File: rtl/vwrite_top.sv
`timescale 1ns/10ps

module vwrite_top #(
   parameter int ADDR_W = 10
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run_i,
   input  logic                     running_i,
   output logic                     done_o,
   input  logic                     ping_pong_i,
   input  vwrite_pkg::word_t        in_data_i,
   input  vwrite_pkg::agen_cfg_t    store_cfg_i,
   input  vwrite_pkg::agen_cfg_t    read_cfg_i,
   input  vwrite_pkg::xfer_cfg_t    xfer_cfg_i,
   output vwrite_pkg::databus_req_t databus_o,
   input  logic                     databus_ready_i,
   input  logic                     databus_last_i
);

   logic              mem_we;
   logic [ADDR_W-1:0] mem_waddr;
   vwrite_pkg::word_t mem_wdata;
   logic              mem_re;
   logic [ADDR_W-1:0] mem_raddr;
   vwrite_pkg::word_t mem_rdata;

   vwrite_unit #(.ADDR_W(ADDR_W)) unit (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i),
      .running_i      (running_i),
      .ping_pong_i    (ping_pong_i),
      .in_data_i      (in_data_i),
      .store_cfg_i    (store_cfg_i),
      .read_cfg_i     (read_cfg_i),
      .xfer_cfg_i     (xfer_cfg_i),
      .done_o         (done_o),
      .databus_o      (databus_o),
      .databus_ready_i(databus_ready_i),
      .databus_last_i (databus_last_i),
      .mem_we_o       (mem_we),
      .mem_waddr_o    (mem_waddr),
      .mem_wdata_o    (mem_wdata),
      .mem_re_o       (mem_re),
      .mem_raddr_o    (mem_raddr),
      .mem_rdata_i    (mem_rdata)
   );

   buffer_mem_2p #(.ADDR_W(ADDR_W)) buffer (
      .clk    (clk),
      .we_i   (mem_we),
      .waddr_i(mem_waddr),
      .wdata_i(mem_wdata),
      .re_i   (mem_re),
      .raddr_i(mem_raddr),
      .rdata_o(mem_rdata)
   );

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
   output logic clk_o
);

   // 4 ns period
   initial begin
      clk_o = 1'b0;
   end

   always #2 clk_o = ~clk_o;

endmodule

// File: dv/databus_slave.sv
`timescale 1ns/10ps

module databus_slave (
   input  logic                     clk,
   input  logic                     rst,
   input  vwrite_pkg::databus_req_t bus_i,
   input  logic                     stalls_i,
   output logic                     ready_o,
   output logic                     last_o
);

   integer                 seed;
   vwrite_pkg::burst_len_t beat_q;

   // captured beats and the byte address of each beat
   vwrite_pkg::word_t      data_q[$];
   vwrite_pkg::ext_addr_t  addr_q[$];
   // one entry per burst
   vwrite_pkg::ext_addr_t  burst_addr_q[$];
   vwrite_pkg::burst_len_t burst_len_q[$];

   initial begin
      seed    = 32'hc197_4ce7;
      ready_o = 1'b0;
   end

   // ready drops about one cycle in four when stalls are on
   always @(negedge clk) begin
      if (stalls_i) begin
         ready_o = (($random(seed) & 3) != 0);
      end else begin
         ready_o = 1'b1;
      end
   end

   // final beat is number len plus one
   assign last_o = bus_i.valid && (beat_q == bus_i.len);

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         beat_q <= '0;
      end else if (bus_i.valid && ready_o) begin
         if (beat_q == '0) begin
            burst_addr_q.push_back(bus_i.addr);
            burst_len_q.push_back(bus_i.len);
         end
         data_q.push_back(bus_i.wdata);
         addr_q.push_back(bus_i.addr + vwrite_pkg::ext_addr_t'({22'd0, beat_q, 2'b00}));
         if (last_o) begin
            beat_q <= '0;
         end else begin
            beat_q <= beat_q + 8'd1;
         end
      end
   end

endmodule

// File: dv/tb_vwrite.sv
`timescale 1ns/10ps

module tb_vwrite;

   localparam int ADDR_W         = 10;
   localparam int TIMEOUT_CYCLES = 4000;

   logic                     clk;
   logic                     rst;
   logic                     run;
   logic                     running;
   logic                     ping_pong;
   logic                     done;
   vwrite_pkg::word_t        in_data;
   vwrite_pkg::agen_cfg_t    store_cfg;
   vwrite_pkg::agen_cfg_t    read_cfg;
   vwrite_pkg::xfer_cfg_t    xfer_cfg;
   vwrite_pkg::databus_req_t bus;
   logic                     bus_ready;
   logic                     bus_last;
   logic                     stalls;
   logic                     xfer_off;
   integer                   seed;
   int                       cycles;
   logic                     pp_model;

   // reference copy of the buffer with the half as top address bit
   vwrite_pkg::word_t        model_mem [2**ADDR_W];
   vwrite_pkg::word_t        exp_data_q[$];
   vwrite_pkg::ext_addr_t    exp_addr_q[$];
   vwrite_pkg::ext_addr_t    exp_burst_addr_q[$];
   vwrite_pkg::burst_len_t   exp_burst_len_q[$];

   tb_clock clock_gen (.clk_o(clk));

   databus_slave slave_inst (
      .clk     (clk),
      .rst     (rst),
      .bus_i   (bus),
      .stalls_i(stalls),
      .ready_o (bus_ready),
      .last_o  (bus_last)
   );

   vwrite_top #(.ADDR_W(ADDR_W)) vwrite_top_inst (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run),
      .running_i      (running),
      .done_o         (done),
      .ping_pong_i    (ping_pong),
      .in_data_i      (in_data),
      .store_cfg_i    (store_cfg),
      .read_cfg_i     (read_cfg),
      .xfer_cfg_i     (xfer_cfg),
      .databus_o      (bus),
      .databus_ready_i(bus_ready),
      .databus_last_i (bus_last)
   );

   task automatic stop_with_fail(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "run stopped at first error");
   endtask

   function automatic string mismatch_text(input string msg);
      return $sformatf("mismatch at %0t ns: %s", $time, msg);
   endfunction

   function automatic vwrite_pkg::agen_cfg_t make_pattern(input int start, input int incr,
         input int period, input int duty, input int iters, input int shift);
      vwrite_pkg::agen_cfg_t cfg;
      cfg.start      = vwrite_pkg::cfg_addr_t'(start);
      cfg.incr       = vwrite_pkg::cfg_addr_t'(incr);
      cfg.period     = vwrite_pkg::period_t'(period);
      cfg.duty       = vwrite_pkg::period_t'(duty);
      cfg.iterations = vwrite_pkg::cfg_addr_t'(iters);
      cfg.shift      = vwrite_pkg::cfg_addr_t'(shift);
      cfg.delay      = '0;
      return cfg;
   endfunction

   function automatic int slot_addr(input vwrite_pkg::agen_cfg_t cfg, input int i, input int j);
      return (int'(cfg.start) + int'(cfg.shift) * i + int'(cfg.incr) * j) % (2**(ADDR_W-1));
   endfunction

   done_drop_a: assert property (@(posedge clk) disable iff (rst) run |=> !done)
      else stop_with_fail(mismatch_text("done_o still high after a run pulse"));

   no_xfer_a: assert property (@(posedge clk) disable iff (rst) xfer_off |-> !bus.valid)
      else stop_with_fail(mismatch_text("databus valid in a run without transfer"));

   // request stays put for the whole burst
   burst_hold_a: assert property (@(posedge clk) disable iff (rst)
      bus.valid && !(bus_ready && bus_last) |=>
         bus.valid && $stable(bus.addr) && $stable(bus.len))
      else stop_with_fail(mismatch_text("databus request changed inside a burst"));

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         stop_with_fail("timeout, done never came back within the cycle limit");
      end
   end

   task automatic check_transfer(input int data_base, input int burst_base);
      assert (slave_inst.data_q.size() - data_base == exp_data_q.size())
         else stop_with_fail(mismatch_text($sformatf("beat count %0d, expected %0d",
            slave_inst.data_q.size() - data_base, exp_data_q.size())));
      for (int k = 0; k < exp_data_q.size(); k++) begin
         assert (slave_inst.data_q[data_base + k] == exp_data_q[k])
            else stop_with_fail(mismatch_text($sformatf("beat %0d data %h, expected %h", k,
               slave_inst.data_q[data_base + k], exp_data_q[k])));
         assert (slave_inst.addr_q[data_base + k] == exp_addr_q[k])
            else stop_with_fail(mismatch_text($sformatf("beat %0d address %h, expected %h",
               k, slave_inst.addr_q[data_base + k], exp_addr_q[k])));
      end
      assert (slave_inst.burst_len_q.size() - burst_base == exp_burst_len_q.size())
         else stop_with_fail(mismatch_text("wrong number of bursts"));
      for (int b = 0; b < exp_burst_len_q.size(); b++) begin
         assert (slave_inst.burst_len_q[burst_base + b] == exp_burst_len_q[b] &&
                 slave_inst.burst_addr_q[burst_base + b] == exp_burst_addr_q[b])
            else stop_with_fail(mismatch_text($sformatf("burst %0d addr %h len %0d", b,
               slave_inst.burst_addr_q[burst_base + b], slave_inst.burst_len_q[burst_base + b])));
      end
   endtask

   task automatic run_pattern(input vwrite_pkg::agen_cfg_t s_cfg,
         input vwrite_pkg::agen_cfg_t r_cfg, input logic enabled, input int amount_m1,
         input int length, input vwrite_pkg::ext_addr_t ext, input logic with_stalls);
      int                    data_base;
      int                    burst_base;
      int                    n_read;
      int                    rem;
      int                    n;
      int                    i;
      int                    j;
      vwrite_pkg::ext_addr_t a;
      vwrite_pkg::word_t     w;
      data_base  = slave_inst.data_q.size();
      burst_base = slave_inst.burst_len_q.size();
      pp_model   = ping_pong ? !pp_model : 1'b0;
      exp_data_q.delete();
      exp_addr_q.delete();
      exp_burst_addr_q.delete();
      exp_burst_len_q.delete();
      if (enabled) begin
         // read side walks the other half with its own pattern
         n_read = 0;
         for (int ri = 0; ri < int'(r_cfg.iterations); ri++) begin
            for (int rj = 0; rj < int'(r_cfg.duty); rj++) begin
               if (n_read <= amount_m1) begin
                  exp_data_q.push_back(model_mem[{!pp_model, 9'(slot_addr(r_cfg, ri, rj))}]);
                  exp_addr_q.push_back(ext + vwrite_pkg::ext_addr_t'(4 * n_read));
                  n_read++;
               end
            end
         end
         rem = amount_m1 + 1;
         a   = ext;
         while (rem > 0) begin
            n = (rem < length + 1) ? rem : length + 1;
            exp_burst_addr_q.push_back(a);
            exp_burst_len_q.push_back(vwrite_pkg::burst_len_t'(n - 1));
            a   = a + vwrite_pkg::ext_addr_t'(4 * n);
            rem = rem - n;
         end
      end
      @(negedge clk);
      store_cfg                 = s_cfg;
      read_cfg                  = r_cfg;
      xfer_cfg.ext_addr         = ext;
      xfer_cfg.amount_minus_one = vwrite_pkg::cfg_addr_t'(amount_m1);
      xfer_cfg.length           = vwrite_pkg::burst_len_t'(length);
      xfer_cfg.enabled          = enabled;
      stalls                    = with_stalls;
      xfer_off                  = !enabled;
      run                       = 1'b1;
      @(negedge clk);
      run = 1'b0;
      // one store slot per cycle starting right after the run
      for (int k = 0; k < int'(s_cfg.period) * int'(s_cfg.iterations); k++) begin
         w       = $random(seed);
         in_data = w;
         i       = k / int'(s_cfg.period);
         j       = k % int'(s_cfg.period);
         if (j < int'(s_cfg.duty)) begin
            model_mem[{pp_model, 9'(slot_addr(s_cfg, i, j))}] = w;
         end
         @(negedge clk);
      end
      while (!done) begin
         @(negedge clk);
      end
      check_transfer(data_base, burst_base);
      xfer_off = 1'b0;
   endtask

   initial begin
      seed      = 32'hc197_4ce7;
      cycles    = 0;
      pp_model  = 1'b0;
      rst       = 1'b1;
      run       = 1'b0;
      running   = 1'b1;
      ping_pong = 1'b1;
      in_data   = '0;
      store_cfg = '0;
      read_cfg  = '0;
      xfer_cfg  = '0;
      stalls    = 1'b0;
      xfer_off  = 1'b0;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      assert (done && !bus.valid)
         else stop_with_fail(mismatch_text("done low or databus valid after reset"));

      // fill one half only without a transfer
      run_pattern(make_pattern(0, 1, 64, 64, 1, 0), make_pattern(0, 1, 64, 64, 1, 0),
                  1'b0, 63, 15, 32'h0000_1000, 1'b0);
      // read back run one in four bursts while storing a strided pattern
      run_pattern(make_pattern(0, 2, 4, 2, 8, 8), make_pattern(0, 1, 64, 64, 1, 0),
                  1'b1, 63, 15, 32'h0000_1000, 1'b0);
      // strided read under random ready
      run_pattern(make_pattern(0, 1, 64, 64, 1, 0), make_pattern(0, 2, 4, 2, 8, 8),
                  1'b1, 15, 15, 32'h0000_2000, 1'b1);
      // 20 words in bursts of 8, 8 and 4
      run_pattern(make_pattern(0, 1, 64, 64, 1, 0), make_pattern(0, 1, 20, 20, 1, 0),
                  1'b1, 19, 7, 32'h0000_3000, 1'b1);

      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: all.f
rtl/vwrite_pkg.sv
rtl/addr_gen.sv
rtl/mem_reader.sv
rtl/databus_burst.sv
rtl/buffer_mem_2p.sv
rtl/vwrite_unit.sv
rtl/vwrite_top.sv
dv/tb_clock.sv
dv/databus_slave.sv
dv/tb_vwrite.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide on the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_vwrite -f all.f -o tb_vwrite \
   > build.log 2>&1 && ./obj_dir/tb_vwrite > sim.log 2>&1 || echo "build or run ended with an error"
grep -q "=== PASS ===" sim.log 2>/dev/null && echo "simulation passed" || {
   echo "simulation failed, see build.log and sim.log"
   exit 1
}
exit 0
